// ==== hdl/coreCtrlPkg.sv ====
// Internal control types of the core for data words, register indices and ALU operations
`default_nettype none

`include "core_config.svh"

package coreCtrlPkg;

  ////////////////////
  // Datapath words
  ////////////////////
  typedef logic [`CORE_XLEN-1:0]      dataT;   // Operand or result
  typedef logic [`CORE_REG_IDX_W-1:0] regIdxT; // x0..x31 index

  ////////////////////
  // ALU operations
  ////////////////////
  // Encoding is internal only, decode picks one per instruction
  typedef enum logic [3:0] {
    ADD,  // Also LUI/AUIPC and unsupported
    SUB,
    SLL,  // Shift by low 5 bits
    SLT,  // Signed compare
    SLTU, // Unsigned compare
    XOR,
    SRL,
    SRA,  // Sign fill
    OR,
    AND
  } aluOpT;

endpackage

`default_nettype wire

// ==== hdl/coreDecode.sv ====
// Decode stage mapping an instruction word to ALU control and immediate, registered into execute
`default_nettype none

module coreDecode
  import rvIsaPkg::*, coreCtrlPkg::*;
(
  input  logic   Clk,
  input  logic   rstN,
  input  logic   instrValid, // One-cycle strobe
  input  instrT  instr,
  input  dataT   pc,
  // Register file read ports
  output regIdxT rdIdx1,
  output regIdxT rdIdx2,
  input  dataT   rdData1,
  input  dataT   rdData2,
  // Registered into execute
  output logic   exeValid,
  output logic   exeSelPc,
  output logic   exeSelImm,
  output logic   exeLui,
  output logic   exeRegWrEn,
  output aluOpT  exeAluOp,
  output regIdxT exeRegDst,
  output regIdxT exeSrc1,
  output regIdxT exeSrc2,
  output dataT   exeRdData1,
  output dataT   exeRdData2,
  output dataT   exeImm,
  output dataT   exePc
);

  // Instruction fields
  opcodeT opcode;
  funct3T funct3;
  funct7T funct7;
  regIdxT regDst;
  regIdxT src1;
  regIdxT src2;

  // Decoded control
  aluOpT  aluOp;
  logic   supported;
  logic   selPc;
  logic   selImm;
  logic   lui;
  logic   regWrEn;
  dataT   imm;

  ////////////////////
  // Field split
  ////////////////////
  assign opcode = opcodeT'(instr[6:0]); // May hold an unlisted value
  assign regDst = instr[11:7];
  assign funct3 = instr[14:12];
  assign src1   = instr[19:15];
  assign src2   = instr[24:20];
  assign funct7 = instr[31:25];

  assign rdIdx1 = src1; // Register file read runs in parallel with decode
  assign rdIdx2 = src2;

  ////////////////////
  // ALU operation
  ////////////////////
  always_comb begin
    casez ({funct3, funct7, opcode})
      // R type
      {F3_ADD,  F7_BASE,    R_OP}: aluOp = ADD;
      {F3_ADD,  F7_ALT,     R_OP}: aluOp = SUB;
      {F3_SLL,  F7_BASE,    R_OP}: aluOp = SLL;
      {F3_SLT,  F7_BASE,    R_OP}: aluOp = SLT;
      {F3_SLTU, F7_BASE,    R_OP}: aluOp = SLTU;
      {F3_XOR,  F7_BASE,    R_OP}: aluOp = XOR;
      {F3_SR,   F7_BASE,    R_OP}: aluOp = SRL;
      {F3_SR,   F7_ALT,     R_OP}: aluOp = SRA;
      {F3_OR,   F7_BASE,    R_OP}: aluOp = OR;
      {F3_AND,  F7_BASE,    R_OP}: aluOp = AND;
      // I type, funct7 only matters for shifts
      {F3_ADD,  7'b???????, I_OP}: aluOp = ADD;
      {F3_SLT,  7'b???????, I_OP}: aluOp = SLT;
      {F3_SLTU, 7'b???????, I_OP}: aluOp = SLTU;
      {F3_XOR,  7'b???????, I_OP}: aluOp = XOR;
      {F3_OR,   7'b???????, I_OP}: aluOp = OR;
      {F3_AND,  7'b???????, I_OP}: aluOp = AND;
      {F3_SLL,  F7_BASE,    I_OP}: aluOp = SLL;
      {F3_SR,   F7_BASE,    I_OP}: aluOp = SRL;
      {F3_SR,   F7_ALT,     I_OP}: aluOp = SRA;
      default:                     aluOp = ADD; // LUI, AUIPC, anything unmatched
    endcase
  end

  ////////////////////
  // Operand control
  ////////////////////
  assign supported = opcode inside {LUI, AUIPC, I_OP, R_OP};
  assign selPc     = (opcode == AUIPC);  // pc as operand 1
  assign selImm    = (opcode != R_OP);   // Immediate unless reg-reg
  assign lui       = (opcode == LUI);
  assign regWrEn   = supported && (regDst != '0); // x0 writes dropped here

  // U immediate for LUI/AUIPC, sign-extended I immediate otherwise
  assign imm = (opcode == LUI || opcode == AUIPC) ? {instr[31:12], 12'b0}
                                                  : {{20{instr[31]}}, instr[31:20]};

  // Valid and write enable
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      exeValid   <= 1'b0;
      exeRegWrEn <= 1'b0;
    end else begin
      exeValid   <= instrValid;
      exeRegWrEn <= instrValid && regWrEn;
    end
  end

  // Payload only loads on an accepted instruction
  always_ff @(posedge Clk) begin
    if (instrValid) begin
      exeAluOp   <= aluOp;
      exeSelPc   <= selPc;
      exeSelImm  <= selImm;
      exeLui     <= lui;
      exeRegDst  <= regDst;
      exeSrc1    <= src1;
      exeSrc2    <= src2;
      exeRdData1 <= rdData1; // Already bypassed by the register file
      exeRdData2 <= rdData2;
      exeImm     <= imm;
      exePc      <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/coreExecute.sv ====
// Execute stage with result forwarding, operand selection and the ALU, registered into result
`default_nettype none

module coreExecute
  import coreCtrlPkg::*;
(
  input  logic   Clk,
  input  logic   rstN,
  // From decode
  input  logic   exeValid,
  input  logic   exeSelPc,
  input  logic   exeSelImm,
  input  logic   exeLui,
  input  logic   exeRegWrEn,
  input  aluOpT  exeAluOp,
  input  regIdxT exeRegDst,
  input  regIdxT exeSrc1,
  input  regIdxT exeSrc2,
  input  dataT   exeRdData1,
  input  dataT   exeRdData2,
  input  dataT   exeImm,
  input  dataT   exePc,
  // Result stage, also looped back for forwarding
  output logic   resValid,
  output logic   resRegWrEn,
  output regIdxT resRegDst,
  output dataT   resData
);

  logic       fwd1;   // Result stage hits source 1
  logic       fwd2;
  dataT       opnd1;  // Register operands after forwarding
  dataT       opnd2;
  dataT       aluIn1;
  dataT       aluIn2;
  dataT       aluOut;
  logic [4:0] shamt;

  ////////////////////
  // Forwarding
  ////////////////////
  // resRegWrEn is never set for x0, so no zero check on the sources
  assign fwd1  = resValid && resRegWrEn && (resRegDst == exeSrc1);
  assign fwd2  = resValid && resRegWrEn && (resRegDst == exeSrc2);
  assign opnd1 = fwd1 ? resData : exeRdData1;
  assign opnd2 = fwd2 ? resData : exeRdData2;

  // Operand muxes
  assign aluIn1 = exeSelPc  ? exePc  : opnd1; // AUIPC
  assign aluIn2 = exeSelImm ? exeImm : opnd2;
  assign shamt  = aluIn2[4:0];               // Low 5 bits only

  ////////////////////
  // ALU
  ////////////////////
  always_comb begin
    case (exeAluOp)
      ADD:     aluOut = aluIn1 + aluIn2;
      SUB:     aluOut = aluIn1 - aluIn2;
      SLL:     aluOut = aluIn1 << shamt;
      SLT:     aluOut = dataT'($signed(aluIn1) < $signed(aluIn2));
      SLTU:    aluOut = dataT'(aluIn1 < aluIn2);
      XOR:     aluOut = aluIn1 ^ aluIn2;
      SRL:     aluOut = aluIn1 >> shamt;
      SRA:     aluOut = $signed(aluIn1) >>> shamt; // Sign fill
      OR:      aluOut = aluIn1 | aluIn2;
      AND:     aluOut = aluIn1 & aluIn2;
      default: aluOut = aluIn1 + aluIn2;
    endcase
    if (exeLui) begin
      aluOut = exeImm; // Upper immediate straight through
    end
  end

  // Result stage control
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      resValid   <= 1'b0;
      resRegWrEn <= 1'b0;
    end else begin
      resValid   <= exeValid;
      resRegWrEn <= exeValid && exeRegWrEn;
    end
  end

  // Result payload
  always_ff @(posedge Clk) begin
    if (exeValid) begin
      resRegDst <= exeRegDst;
      resData   <= aluOut;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/coreTop.sv ====
// Top level of the three-stage RV32I integer datapath with the writeback shown on output ports
`default_nettype none

module coreTop
  import rvIsaPkg::*, coreCtrlPkg::*;
(
  input  logic   Clk,
  input  logic   rstN,
  input  logic   instrValid, // Accept strobe, no back-pressure
  input  instrT  instr,
  input  dataT   pc,         // Used by AUIPC only
  output logic   wbValid,    // Two cycles after acceptance
  output logic   wbRegWrEn,
  output regIdxT wbRegDst,
  output dataT   wbData
);

  // Decode to register file
  regIdxT rdIdx1, rdIdx2;
  dataT   rdData1, rdData2;

  // Decode to execute
  logic   exeValid, exeSelPc, exeSelImm, exeLui, exeRegWrEn;
  aluOpT  exeAluOp;
  regIdxT exeRegDst, exeSrc1, exeSrc2;
  dataT   exeRdData1, exeRdData2, exeImm, exePc;

  // Result stage
  logic   resValid, resRegWrEn;
  regIdxT resRegDst;
  dataT   resData;

  ////////////////////
  // Stages
  ////////////////////
  coreDecode decode_i (
    .Clk        (Clk),        .rstN       (rstN),
    .instrValid (instrValid), .instr      (instr),      .pc         (pc),
    .rdIdx1     (rdIdx1),     .rdIdx2     (rdIdx2),
    .rdData1    (rdData1),    .rdData2    (rdData2),
    .exeValid   (exeValid),   .exeSelPc   (exeSelPc),   .exeSelImm  (exeSelImm),
    .exeLui     (exeLui),     .exeRegWrEn (exeRegWrEn), .exeAluOp   (exeAluOp),
    .exeRegDst  (exeRegDst),  .exeSrc1    (exeSrc1),    .exeSrc2    (exeSrc2),
    .exeRdData1 (exeRdData1), .exeRdData2 (exeRdData2),
    .exeImm     (exeImm),     .exePc      (exePc)
  );

  coreExecute execute_i (
    .Clk        (Clk),        .rstN       (rstN),
    .exeValid   (exeValid),   .exeSelPc   (exeSelPc),   .exeSelImm  (exeSelImm),
    .exeLui     (exeLui),     .exeRegWrEn (exeRegWrEn), .exeAluOp   (exeAluOp),
    .exeRegDst  (exeRegDst),  .exeSrc1    (exeSrc1),    .exeSrc2    (exeSrc2),
    .exeRdData1 (exeRdData1), .exeRdData2 (exeRdData2),
    .exeImm     (exeImm),     .exePc      (exePc),
    .resValid   (resValid),   .resRegWrEn (resRegWrEn),
    .resRegDst  (resRegDst),  .resData    (resData)
  );

  coreWriteback writeback_i (
    .Clk        (Clk),        .rstN       (rstN),
    .resValid   (resValid),   .resRegWrEn (resRegWrEn),
    .resRegDst  (resRegDst),  .resData    (resData),
    .rdIdx1     (rdIdx1),     .rdIdx2     (rdIdx2),
    .rdData1    (rdData1),    .rdData2    (rdData2)
  );

  // Result stage is the visible writeback
  assign wbValid   = resValid;
  assign wbRegWrEn = resRegWrEn;
  assign wbRegDst  = resRegDst;
  assign wbData    = resData;

endmodule

`default_nettype wire

// ==== hdl/coreWriteback.sv ====
// Result stage write into the 32-entry register file with two bypassed read ports
`default_nettype none

`include "core_config.svh"

module coreWriteback
  import coreCtrlPkg::*;
(
  input  logic   Clk,
  input  logic   rstN,
  // Result stage
  input  logic   resValid,
  input  logic   resRegWrEn,
  input  regIdxT resRegDst,
  input  dataT   resData,
  // Read ports for decode
  input  regIdxT rdIdx1,
  input  regIdxT rdIdx2,
  output dataT   rdData1,
  output dataT   rdData2
);

  dataT regFile [1:`CORE_NUM_REGS-1]; // x0 has no storage
  logic wrEn;

  assign wrEn = resValid && resRegWrEn && (resRegDst != '0);

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < `CORE_NUM_REGS; i++) begin
        regFile[i] <= '0; // Every register reads zero out of reset
      end
    end else if (wrEn) begin
      regFile[resRegDst] <= resData;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////
  // Same lookup for both ports
  function automatic dataT readPort(input regIdxT idx);
    dataT data;
    if (idx == '0) begin
      data = '0;                 // x0 hardwired
    end else if (wrEn && idx == resRegDst) begin
      data = resData;            // Write-before-read bypass
    end else begin
      data = regFile[idx];
    end
    return data;
  endfunction

  always_comb begin
    rdData1 = readPort(rdIdx1);
    rdData2 = readPort(rdIdx2);
  end

endmodule

`default_nettype wire

// ==== hdl/rvIsaPkg.sv ====
// RV32I instruction encoding with opcodes, function fields and the instruction word type
`default_nettype none

`include "core_config.svh"

package rvIsaPkg;

  typedef logic [`CORE_INSTR_W-1:0] instrT; // Raw instruction word

  ////////////////////
  // Major opcodes
  ////////////////////
  // Only the integer ALU groups are listed, any other value is unsupported
  typedef enum logic [6:0] {
    LUI   = 7'b0110111, // Load upper immediate
    AUIPC = 7'b0010111, // Add upper immediate to pc
    I_OP  = 7'b0010011, // Register-immediate ALU
    R_OP  = 7'b0110011  // Register-register ALU
  } opcodeT;

  typedef logic [2:0] funct3T; // Bits 14:12
  typedef logic [6:0] funct7T; // Bits 31:25

  ////////////////////
  // funct7 values
  ////////////////////
  localparam funct7T F7_BASE = 7'b0000000; // Plain op
  localparam funct7T F7_ALT  = 7'b0100000; // SUB and SRA/SRAI

  ////////////////////
  // funct3 values
  ////////////////////
  localparam funct3T F3_ADD  = 3'b000; // ADD, SUB, ADDI
  localparam funct3T F3_SLL  = 3'b001;
  localparam funct3T F3_SLT  = 3'b010;
  localparam funct3T F3_SLTU = 3'b011;
  localparam funct3T F3_XOR  = 3'b100;
  localparam funct3T F3_SR   = 3'b101; // SRL and SRA share it
  localparam funct3T F3_OR   = 3'b110;
  localparam funct3T F3_AND  = 3'b111;

endpackage

`default_nettype wire

// ==== include/core_config.svh ====
// Width and size macros for the three-stage RV32I integer datapath
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////
// Datapath widths
////////////////////
`define CORE_XLEN      32  // Data word width
`define CORE_INSTR_W   32  // Instruction word width

////////////////////
// Register file
////////////////////
// Index width must cover the register count
`define CORE_NUM_REGS  32  // x0 up to x31
`define CORE_REG_IDX_W 5   // log2 of the register count

`endif

// ==== run.sh ====
#!/bin/sh
# Compile and run the coreTb simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module coreTb \
  -f tb.f \
  -Mdir obj_dir \
  -o coreSim

out=$(./obj_dir/coreSim)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

// ==== tb.f ====
+incdir+include
hdl/rvIsaPkg.sv
hdl/coreCtrlPkg.sv
hdl/coreDecode.sv
hdl/coreExecute.sv
hdl/coreWriteback.sv
hdl/coreTop.sv
verif/core_assert.sv
verif/coreTb.sv

// ==== verif/coreTb.sv ====
// Testbench for the three-stage RV32I datapath with a shadow register file and in-order checker
`default_nettype none

`include "core_config.svh"

module coreTb
  import rvIsaPkg::*, coreCtrlPkg::*;
;

  localparam int DRIVE_DELAY    = 2;                        // After the rising edge
  localparam int NUM_DIRECTED   = 39;                       // Readback plus hazard chain
  localparam int NUM_RANDOM     = 300;
  localparam int NUM_INSTR      = NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 2 + 50;       // At most one idle slot each

  // One expected writeback
  typedef struct packed {
    logic        wrEn;
    regIdxT      dst;
    dataT        data;
    logic [31:0] due;  // Cycle count when wbValid must show
  } expectT;

  logic        Clk = 1'b0;
  logic        rstN;
  logic        instrValid;
  instrT       instr;
  dataT        pc;
  logic        wbValid;
  logic        wbRegWrEn;
  regIdxT      wbRegDst;
  dataT        wbData;

  logic [31:0] cycleCnt = '0;
  integer      seed;
  int          errorCount;
  int          checkCount;
  dataT        pcCnt;
  dataT        shadowRegs [`CORE_NUM_REGS];  // Architectural state as seen by software
  expectT      expQ [$];                     // Oldest first

  coreTop dut_i (
    .Clk        (Clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .pc         (pc),
    .wbValid    (wbValid),
    .wbRegWrEn  (wbRegWrEn),
    .wbRegDst   (wbRegDst),
    .wbData     (wbData)
  );

  initial begin
    forever #20 Clk = ~Clk; // Period 40
  end

  always @(posedge Clk) cycleCnt <= cycleCnt + 1;

  ////////////////////
  // Encoders
  ////////////////////
  function automatic instrT buildRType(input logic [6:0] f7, input regIdxT rs2,
                                       input regIdxT rs1, input logic [2:0] f3,
                                       input regIdxT rd);
    return {f7, rs2, rs1, f3, rd, R_OP};
  endfunction

  function automatic instrT buildIType(input logic [11:0] imm, input regIdxT rs1,
                                       input logic [2:0] f3, input regIdxT rd);
    return {imm, rs1, f3, rd, I_OP};
  endfunction

  function automatic instrT buildUType(input logic [6:0] op, input logic [19:0] imm,
                                       input regIdxT rd);
    return {imm, rd, op};
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  function automatic logic writesReg(input instrT ins);
    logic known;
    known = (ins[6:0] == LUI) || (ins[6:0] == AUIPC) || (ins[6:0] == I_OP) ||
            (ins[6:0] == R_OP);
    return known && (ins[11:7] != 5'd0); // x0 never written
  endfunction

  function automatic dataT refResult(input instrT ins, input dataT pcVal);
    dataT       a;
    dataT       b;
    dataT       res;
    logic [4:0] sh;
    logic       alt;
    logic       isReg;
    logic       sLess;
    isReg = (ins[6:0] == R_OP);
    a     = shadowRegs[ins[19:15]];                                    // x0 holds zero
    b     = isReg ? shadowRegs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    sh    = b[4:0];
    alt   = ins[30];                                                   // SUB, SRA, SRAI
    sLess = (a[31] != b[31]) ? a[31] : (a < b);                        // Sign first
    if (ins[6:0] == LUI) begin
      res = {ins[31:12], 12'h000};
    end else if (ins[6:0] == AUIPC) begin
      res = pcVal + {ins[31:12], 12'h000};
    end else begin
      case (ins[14:12])
        3'd0:    res = (alt && isReg) ? a - b : a + b;
        3'd1:    res = a << sh;
        3'd2:    res = {31'd0, sLess};
        3'd3:    res = {31'd0, a < b};
        3'd4:    res = a ^ b;
        3'd5:    res = (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
        3'd6:    res = a | b;
        default: res = a & b;
      endcase
    end
    return res;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////
  // Registers x0..x7 only, to make hazards common
  function automatic instrT randomInstr();
    int unsigned kind;
    logic [31:0] bits;
    regIdxT      rd;
    regIdxT      rs1;
    regIdxT      rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  op;
    instrT       ins;
    kind = $unsigned($random(seed)) % 16;
    bits = $random(seed);
    rd   = {2'b00, bits[2:0]};
    rs1  = {2'b00, bits[5:3]};
    rs2  = {2'b00, bits[8:6]};
    f3   = bits[11:9];
    bits = $random(seed);                                  // Fresh bits for immediates
    if (kind < 6) begin
      f7  = ((f3 == F3_ADD || f3 == F3_SR) && bits[0]) ? F7_ALT : F7_BASE;
      ins = buildRType(f7, rs2, rs1, f3, rd);
    end else if (kind < 13) begin
      if (f3 == F3_SLL) begin
        ins = buildIType({F7_BASE, bits[4:0]}, rs1, f3, rd);
      end else if (f3 == F3_SR) begin
        ins = buildIType({bits[5] ? F7_ALT : F7_BASE, bits[4:0]}, rs1, f3, rd);
      end else begin
        ins = buildIType(bits[31:20], rs1, f3, rd);
      end
    end else if (kind == 13) begin
      ins = buildUType(LUI, bits[31:12], rd);
    end else if (kind == 14) begin
      ins = buildUType(AUIPC, bits[31:12], rd);
    end else begin
      case (bits[9:7])                                     // Opcodes outside the ALU set
        3'd0:    op = 7'b0000011;                          // Load
        3'd1:    op = 7'b0100011;                          // Store
        3'd2:    op = 7'b1100011;                          // Branch
        3'd3:    op = 7'b0001111;                          // FENCE
        3'd4:    op = 7'b1110011;                          // SYSTEM
        3'd5:    op = 7'b1101111;                          // JAL
        3'd6:    op = 7'b1100111;                          // JALR
        default: op = 7'b0000000;
      endcase
      ins = {bits[31:12], rd, op};
    end
    return ins;
  endfunction

  task automatic issueInstr(input instrT ins);
    expectT item;
    instrValid = 1'b1;
    instr      = ins;
    pc         = pcCnt;
    item.wrEn  = writesReg(ins);
    item.dst   = ins[11:7];
    item.data  = refResult(ins, pcCnt);
    item.due   = cycleCnt + 2;                             // Sampled next edge, shown after one more
    expQ.push_back(item);
    if (item.wrEn) shadowRegs[item.dst] = item.data;
    pcCnt = pcCnt + 4;
    @(posedge Clk);
    #DRIVE_DELAY;
    instrValid = 1'b0;
  endtask

  task automatic idleCycle();
    instrValid = 1'b0;
    instr      = $random(seed);                            // Garbage that must be ignored
    @(posedge Clk);
    #DRIVE_DELAY;
  endtask

  initial begin
    seed       = 32'h2cfc40b6;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    pc         = '0;
    errorCount = 0;
    checkCount = 0;
    pcCnt      = 32'h0000_1000;
    for (int i = 0; i < `CORE_NUM_REGS; i++) shadowRegs[i] = '0;
    repeat (3) @(posedge Clk);
    #DRIVE_DELAY;
    rstN = 1'b1;
    // Read every register through ADDI x1, xi, 0
    for (int i = 1; i < `CORE_NUM_REGS; i++) begin
      issueInstr(buildIType(12'h000, regIdxT'(i), F3_ADD, 5'd1));
    end
    // Dependent chain, one and two slots apart
    issueInstr(buildIType(12'd100, 5'd0, F3_ADD, 5'd1));
    issueInstr(buildIType(12'd7, 5'd1, F3_ADD, 5'd2));
    issueInstr(buildRType(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3));
    issueInstr(buildRType(F7_ALT, 5'd1, 5'd3, F3_ADD, 5'd1));
    issueInstr(buildUType(LUI, 20'h80000, 5'd4));
    issueInstr(buildIType({F7_ALT, 5'd4}, 5'd4, F3_SR, 5'd5));
    issueInstr(buildRType(F7_BASE, 5'd5, 5'd4, F3_SLT, 5'd6));
    issueInstr(buildIType(12'd1, 5'd1, F3_ADD, 5'd0));     // Write to x0 is dropped
    for (int n = 0; n < NUM_RANDOM; n++) begin
      issueInstr(randomInstr());
      if (($unsigned($random(seed)) % 3) == 0) idleCycle();
    end
    while (expQ.size() != 0) @(posedge Clk);
    repeat (2) @(posedge Clk);
    $display("Results checked: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  ////////////////////
  // Checker
  ////////////////////
  // Outputs settle after the rising edge, so sample on the falling one
  always @(negedge Clk) begin
    expectT head;
    if (!rstN) begin
      assert (!wbValid && !wbRegWrEn) else begin
        errorCount++;
        $display("Writeback outputs active during reset at time %0t", $time);
      end
    end else if (wbValid) begin
      if (expQ.size() == 0) begin
        errorCount++;
        $display("Writeback shown at time %0t with no instruction outstanding", $time);
      end else begin
        head = expQ.pop_front();
        checkCount++;
        assert (cycleCnt == head.due) else begin
          errorCount++;
          $display("MISMATCH at %0t: result in cycle %0d, expected cycle %0d",
                   $time, cycleCnt, head.due);
        end
        assert (wbRegWrEn == head.wrEn) else begin
          errorCount++;
          $display("MISMATCH at %0t: wbRegWrEn %0b, expected %0b", $time, wbRegWrEn, head.wrEn);
        end
        if (head.wrEn) begin                               // Data only matters on a write
          assert (wbRegDst == head.dst) else begin
            errorCount++;
            $display("MISMATCH at %0t: wbRegDst x%0d, expected x%0d", $time, wbRegDst, head.dst);
          end
          assert (wbData == head.data) else begin
            errorCount++;
            $display("MISMATCH at %0t: wbData %h, expected %h", $time, wbData, head.data);
          end
        end
      end
    end else if (expQ.size() != 0 && expQ[0].due <= cycleCnt) begin
      head = expQ.pop_front();                             // Drop it so later results line up
      errorCount++;
      $display("No writeback shown at time %0t for an accepted instruction", $time);
    end
  end

  ////////////////////
  // Timeout
  ////////////////////
  initial begin
    while (cycleCnt < TIMEOUT_CYCLES) @(posedge Clk);
    $display("Run timed out after %0d cycles before all results were seen", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/core_assert.sv ====
// Concurrent checks on the writeback outputs of the three-stage core, bound into coreTop
`default_nettype none

module coreAssert
  import coreCtrlPkg::*;
(
  input logic   Clk,
  input logic   rstN,
  input logic   instrValid,
  input logic   wbValid,
  input logic   wbRegWrEn,
  input regIdxT wbRegDst
);

  ////////////////////
  // Latency
  ////////////////////
  // Sampled at edge N, still high when sampled at edge N+2
  latencyChk: assert property (@(posedge Clk) disable iff (!rstN) instrValid |-> ##2 wbValid)
    else $error("Accepted instruction gave no writeback two cycles later");

  ////////////////////
  // Write qualifiers
  ////////////////////
  wrEnValidChk: assert property (@(posedge Clk) disable iff (!rstN) wbRegWrEn |-> wbValid)
    else $error("Register write shown without wbValid");

  wrEnDstChk: assert property (@(posedge Clk) disable iff (!rstN) wbRegWrEn |-> wbRegDst != '0)
    else $error("Register write shown for x0");

  resetChk: assert property (@(posedge Clk) !rstN |-> !wbValid) // No disable here
    else $error("wbValid high while reset is active");

endmodule

bind coreTop coreAssert assert_i (
  .Clk        (Clk),
  .rstN       (rstN),
  .instrValid (instrValid),
  .wbValid    (wbValid),
  .wbRegWrEn  (wbRegWrEn),
  .wbRegDst   (wbRegDst)
);

`default_nettype wire
